//--- audio_recorder.f
src/aud_pkg.sv
src/aud_if.sv
src/aud_ctrl.sv
src/aud_recorder.sv
src/aud_dsp.sv
src/aud_player.sv
src/aud_top.sv
test/sram_model.sv
test/tb_aud_top.sv

//--- src/aud_ctrl.sv
module aud_ctrl import aud_pkg::*; (
	input  logic       i_AUD_BCLK,
	input  logic       i_rst_n,
	input  logic       i_key_record,
	input  logic       i_key_play,
	input  logic       i_key_stop,
	input  logic [3:0] i_speed,
	input  logic       i_interp,
	output aud_state_e o_state,
	aud_rec_if.ctrl    rec,
	aud_play_if.ctrl   play
);

	aud_state_e          state_r;
	aud_state_e          state_w;
	logic                rec_start;
	logic                play_start;
	logic                slow_r;
	logic                interp_r;
	logic [FACTOR_W-1:0] factor_r;
	logic [FACTOR_W-1:0] factor_w;

	always_comb begin
		state_w = state_r;
		case (state_r)
			S_STOP: begin
				if (i_key_record)
					state_w = S_RECD;
				else if (i_key_play)
					state_w = S_PLAY;
			end
			S_RECD: begin
				if (i_key_stop || rec.full)
					state_w = S_STOP;
				else if (i_key_record)
					state_w = S_RECD_PAUSE;
			end
			S_RECD_PAUSE: begin
				if (i_key_stop)
					state_w = S_STOP;
				else if (i_key_record)
					state_w = S_RECD;
			end
			S_PLAY: begin
				// end of recording ends playback too
				if (i_key_stop || play.done)
					state_w = S_STOP;
				else if (i_key_play)
					state_w = S_PLAY_PAUSE;
			end
			S_PLAY_PAUSE: begin
				if (i_key_stop)
					state_w = S_STOP;
				else if (i_key_play)
					state_w = S_PLAY;
			end
			default: state_w = S_STOP;
		endcase
	end

	// linear mode takes a power-of-two code
	always_comb begin
		if (i_speed[3] && i_interp) begin
			case (i_speed[1:0])
				2'd0:    factor_w = FACTOR_W'(0);
				2'd1:    factor_w = FACTOR_W'(1);
				2'd2:    factor_w = FACTOR_W'(3);
				default: factor_w = FACTOR_W'(7);
			endcase
		end else begin
			factor_w = i_speed[2:0];
		end
	end

	assign rec_start  = (state_r == S_STOP) && (state_w == S_RECD);
	assign play_start = (state_r == S_STOP) && (state_w == S_PLAY);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			state_r  <= S_STOP;
			slow_r   <= 1'b0;
			interp_r <= 1'b0;
			factor_r <= '0;
		end else begin
			state_r <= state_w;
			if (play_start) begin
				slow_r   <= i_speed[3];
				interp_r <= i_speed[3] && i_interp;
				factor_r <= factor_w;
			end
		end
	end

	assign o_state      = state_r;
	assign rec.run      = (state_r == S_RECD);
	assign rec.restart  = rec_start;
	assign play.run     = (state_r == S_PLAY);
	assign play.restart = play_start;
	assign play.slow    = slow_r;
	assign play.interp  = interp_r;
	assign play.factor  = factor_r;

	// a restart leaves no stale full or done flag behind
	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		rec.restart |=> !rec.full && rec.length == '0);
	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		play.restart |=> !play.done);

endmodule

//--- src/aud_dsp.sv
module aud_dsp import aud_pkg::*; (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  logic                i_AUD_DACLRCK,
	input  logic [ADDR_W-1:0]   i_length,
	input  logic [SAMPLE_W-1:0] i_rd_data,
	aud_play_if.dsp             play,
	output logic [ADDR_W-1:0]   o_rd_addr,
	output logic [SAMPLE_W-1:0] o_sample,
	output logic                o_player_en
);

	logic                                lrck_d;
	logic                                left_start;
	logic [ADDR_W:0]                     addr_nxt;
	logic [ADDR_W:0]                     addr_inc;
	logic                                at_end;
	logic [FACTOR_W-1:0]                 step;
	logic                                frame_go;
	logic                                fetch_d1;
	logic                                phase1;
	logic                                phase2;
	logic                                done_r;
	logic [1:0]                          shift;
	logic signed [SAMPLE_W-1:0]          prev;
	logic signed [SAMPLE_W-1:0]          cur;
	logic signed [SAMPLE_W:0]            diff;
	logic signed [SAMPLE_W+FACTOR_W+1:0] prod;
	logic signed [SAMPLE_W-1:0]          interp;

	assign left_start = lrck_d && !i_AUD_DACLRCK;
	// one extra bit so a fast step cannot wrap
	assign at_end     = addr_nxt >= {1'b0, i_length};
	assign addr_inc   = play.slow ? (ADDR_W+1)'(1) : (ADDR_W+1)'(play.factor) + 1'b1;
	// a new address is due at step 0 only
	assign frame_go   = left_start && play.run && !done_r && !(step == '0 && at_end);

	// log2 of the linear factor
	always_comb begin
		case (play.factor)
			FACTOR_W'(1): shift = 2'd1;
			FACTOR_W'(3): shift = 2'd2;
			FACTOR_W'(7): shift = 2'd3;
			default:      shift = 2'd0;
		endcase
	end

	// prev + (cur - prev) * k / F
	assign diff   = cur - prev;
	assign prod   = diff * $signed({1'b0, step});
	assign interp = prev + SAMPLE_W'(prod >>> shift);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d    <= 1'b0;
			addr_nxt  <= '0;
			o_rd_addr <= '0;
			step      <= '0;
			fetch_d1  <= 1'b0;
			phase1    <= 1'b0;
			phase2    <= 1'b0;
			done_r    <= 1'b0;
		end else begin
			lrck_d <= i_AUD_DACLRCK;
			if (play.restart) begin
				addr_nxt  <= '0;
				o_rd_addr <= '0;
				step      <= '0;
				fetch_d1  <= 1'b0;
				phase1    <= 1'b0;
				phase2    <= 1'b0;
				done_r    <= 1'b0;
			end else begin
				phase1 <= frame_go;
				phase2 <= phase1;
				if (left_start && play.run && step == '0 && at_end)
					done_r <= 1'b1;
				// cycle 0 puts the address on the bus
				if (frame_go) begin
					fetch_d1 <= (step == '0);
					if (step == '0) begin
						o_rd_addr <= addr_nxt[ADDR_W-1:0];
						addr_nxt  <= addr_nxt + addr_inc;
					end
				end
				if (phase2)
					step <= (play.slow && step != play.factor) ? step + 1'b1 : '0;
			end
		end
	end

	// cycle 1 takes the SRAM word, cycle 2 hands over the sample
	always_ff @(posedge i_AUD_BCLK) begin
		if (play.restart) begin
			prev     <= '0;
			cur      <= '0;
			o_sample <= '0;
		end else begin
			if (phase1 && fetch_d1) begin
				prev <= cur;
				cur  <= i_rd_data;
			end
			if (phase2)
				o_sample <= (play.slow && play.interp) ? interp : cur;
		end
	end

	assign play.done   = done_r;
	assign o_player_en = play.run;

	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		play.run && i_length != '0 |-> o_rd_addr < i_length);

endmodule

//--- src/aud_if.sv
// controller to recorder
interface aud_rec_if import aud_pkg::*; ();
	logic              run;
	logic              restart;
	logic              full;
	logic [ADDR_W-1:0] length;

	modport ctrl (output run, output restart, input full, input length);
	modport rec  (input run, input restart, output full, output length);
endinterface

// controller to playback DSP
interface aud_play_if import aud_pkg::*; ();
	logic                run;
	logic                restart;
	logic                slow;
	logic                interp;
	logic [FACTOR_W-1:0] factor;
	logic                done;

	modport ctrl (
		output run, output restart, output slow,
		output interp, output factor, input done
	);
	modport dsp (
		input run, input restart, input slow,
		input interp, input factor, output done
	);
endinterface

//--- src/aud_pkg.sv
package aud_pkg;

	// audio word and SRAM geometry
	localparam int SAMPLE_W = 16;
	localparam int ADDR_W   = 20;

	// recording stops once this address holds a word
	localparam logic [ADDR_W-1:0] ADDR_LAST = {ADDR_W{1'b1}};

	// I2S slot length in bit clocks, MSB first
	localparam int SLOT_BITS = 16;
	localparam int BIT_CNT_W = $clog2(SLOT_BITS + 1);

	// speed factor minus one, speeds 1 to 8
	localparam int FACTOR_W = 3;

	// control FSM states
	typedef enum logic [2:0] {
		S_STOP       = 3'd0,
		S_RECD       = 3'd1,
		S_RECD_PAUSE = 3'd2,
		S_PLAY       = 3'd3,
		S_PLAY_PAUSE = 3'd4
	} aud_state_e;

endpackage

//--- src/aud_player.sv
module aud_player import aud_pkg::*; (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  logic                i_AUD_DACLRCK,
	input  logic                i_en,
	input  logic [SAMPLE_W-1:0] i_sample,
	output logic                o_AUD_DACDAT
);

	logic                 lrck_d;
	logic                 slot_start;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [SAMPLE_W-1:0]  shift_r;

	// both slots carry the same word
	assign slot_start = (i_AUD_DACLRCK != lrck_d);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d  <= 1'b0;
			bit_cnt <= '0;
		end else begin
			lrck_d <= i_AUD_DACLRCK;
			if (slot_start)
				bit_cnt <= BIT_CNT_W'(SLOT_BITS);
			else if (bit_cnt != '0)
				bit_cnt <= bit_cnt - 1'b1;
		end
	end

	// zero word while disabled
	always_ff @(posedge i_AUD_BCLK) begin
		if (slot_start)
			shift_r <= i_en ? i_sample : '0;
		else if (bit_cnt != '0)
			shift_r <= {shift_r[SAMPLE_W-2:0], 1'b0};
	end

	// line stays low past the last bit
	assign o_AUD_DACDAT = (bit_cnt != '0) && shift_r[SAMPLE_W-1];

endmodule

//--- src/aud_recorder.sv
module aud_recorder import aud_pkg::*; (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  logic                i_AUD_ADCLRCK,
	input  logic                i_AUD_ADCDAT,
	aud_rec_if.rec              rec,
	output logic [ADDR_W-1:0]   o_wr_addr,
	output logic [SAMPLE_W-1:0] o_wr_data,
	output logic                o_wr_en
);

	logic                 lrck_d;
	logic                 slot_start;
	logic                 left_slot;
	logic [BIT_CNT_W-1:0] bit_cnt;
	logic [SAMPLE_W-1:0]  shift_r;
	logic                 wr_pend;
	logic [ADDR_W-1:0]    length_r;
	logic                 full_r;

	assign slot_start = (i_AUD_ADCLRCK != lrck_d);

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			lrck_d    <= 1'b0;
			left_slot <= 1'b0;
			bit_cnt   <= '0;
			wr_pend   <= 1'b0;
		end else begin
			lrck_d  <= i_AUD_ADCLRCK;
			wr_pend <= 1'b0;
			if (slot_start) begin
				bit_cnt   <= BIT_CNT_W'(SLOT_BITS);
				left_slot <= !i_AUD_ADCLRCK;
			end else if (bit_cnt != '0) begin
				bit_cnt <= bit_cnt - 1'b1;
				// last bit of a left word
				if (bit_cnt == BIT_CNT_W'(1))
					wr_pend <= left_slot && rec.run && !full_r;
			end
		end
	end

	// word shifter that idles on the slot start edge
	always_ff @(posedge i_AUD_BCLK) begin
		if (!slot_start && bit_cnt != '0)
			shift_r <= {shift_r[SAMPLE_W-2:0], i_AUD_ADCDAT};
	end

	// a pause landing on the strobe drops the word
	assign o_wr_en = wr_pend && rec.run;

	always_ff @(posedge i_AUD_BCLK or posedge i_rst_n) begin
		if (i_rst_n) begin
			length_r <= '0;
			full_r   <= 1'b0;
		end else if (rec.restart) begin
			length_r <= '0;
			full_r   <= 1'b0;
		end else if (o_wr_en) begin
			if (length_r == ADDR_LAST)
				full_r <= 1'b1;
			else
				length_r <= length_r + 1'b1;
		end
	end

	assign o_wr_addr  = length_r;
	assign o_wr_data  = shift_r;
	assign rec.length = length_r;
	assign rec.full   = full_r;

	// an LRCK edge only lands between words
	assert property (@(posedge i_AUD_BCLK) disable iff (i_rst_n)
		slot_start |-> bit_cnt == '0);

endmodule

//--- src/aud_top.sv
module aud_top import aud_pkg::*; (
	input  logic                i_AUD_BCLK,
	input  logic                i_rst_n,
	input  logic                i_key_record,
	input  logic                i_key_play,
	input  logic                i_key_stop,
	input  logic [3:0]          i_speed,
	input  logic                i_interp,
	input  logic                i_AUD_ADCDAT,
	input  logic                i_AUD_ADCLRCK,
	input  logic                i_AUD_DACLRCK,
	output logic                o_AUD_DACDAT,
	output logic [ADDR_W-1:0]   o_SRAM_ADDR,
	inout  wire  [SAMPLE_W-1:0] io_SRAM_DQ,
	output logic                o_SRAM_WE_N,
	output logic                o_SRAM_OE_N,
	output aud_state_e          o_state
);

	aud_rec_if  rec_bus ();
	aud_play_if play_bus ();

	logic [ADDR_W-1:0]   wr_addr;
	logic [ADDR_W-1:0]   rd_addr;
	logic [SAMPLE_W-1:0] wr_data;
	logic [SAMPLE_W-1:0] dsp_sample;
	logic                wr_en;
	logic                player_en;
	logic                rec_sel;

	// recorder owns the SRAM only while recording
	assign rec_sel     = (o_state == S_RECD);
	assign o_SRAM_ADDR = rec_sel ? wr_addr : rd_addr;
	assign io_SRAM_DQ  = rec_sel ? wr_data : {SAMPLE_W{1'bz}};
	assign o_SRAM_WE_N = !wr_en;
	assign o_SRAM_OE_N = rec_sel;

	aud_ctrl u_ctrl (
		.i_AUD_BCLK   (i_AUD_BCLK),
		.i_rst_n      (i_rst_n),
		.i_key_record (i_key_record),
		.i_key_play   (i_key_play),
		.i_key_stop   (i_key_stop),
		.i_speed      (i_speed),
		.i_interp     (i_interp),
		.o_state      (o_state),
		.rec          (rec_bus),
		.play         (play_bus)
	);

	aud_recorder u_recorder (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_AUD_ADCLRCK (i_AUD_ADCLRCK),
		.i_AUD_ADCDAT  (i_AUD_ADCDAT),
		.rec           (rec_bus),
		.o_wr_addr     (wr_addr),
		.o_wr_data     (wr_data),
		.o_wr_en       (wr_en)
	);

	aud_dsp u_dsp (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_AUD_DACLRCK (i_AUD_DACLRCK),
		.i_length      (rec_bus.length),
		.i_rd_data     (io_SRAM_DQ),
		.play          (play_bus),
		.o_rd_addr     (rd_addr),
		.o_sample      (dsp_sample),
		.o_player_en   (player_en)
	);

	aud_player u_player (
		.i_AUD_BCLK    (i_AUD_BCLK),
		.i_rst_n       (i_rst_n),
		.i_AUD_DACLRCK (i_AUD_DACLRCK),
		.i_en          (player_en),
		.i_sample      (dsp_sample),
		.o_AUD_DACDAT  (o_AUD_DACDAT)
	);

endmodule

//--- test/sram_model.sv
module sram_model import aud_pkg::*; (
	input  logic [ADDR_W-1:0]   i_addr,
	inout  wire  [SAMPLE_W-1:0] io_dq,
	input  logic                i_we_n,
	input  logic                i_oe_n
);

	logic [SAMPLE_W-1:0] mem [0:(1 << ADDR_W) - 1];

	// bus is driven only for a read with the write strobe idle
	assign io_dq = (!i_oe_n && i_we_n) ? mem[i_addr] : {SAMPLE_W{1'bz}};

	// write lands shortly after the strobe falls, once address and data settle
	always @(negedge i_we_n) begin
		#1;
		if (!i_we_n)
			mem[i_addr] = io_dq;
	end

	// backdoor read for the testbench
	function automatic logic [SAMPLE_W-1:0] peek(input logic [ADDR_W-1:0] addr);
		return mem[addr];
	endfunction

endmodule

//--- test/tb_aud_top.sv
module tb_aud_top import aud_pkg::*; ();

	localparam int CLK_HALF     = 10;
	localparam int FRAME_CYCLES = 2 * (SLOT_BITS + 1);
	localparam int K_RECORD     = 0;
	localparam int K_PLAY       = 1;
	localparam int K_STOP       = 2;
	// frames per test in run order with the sync frame
	localparam int TOTAL_FRAMES = 1 + 14 + 13 + 12 + 7 + 20 + 20 + 10;
	localparam int MARGIN       = 500;
	localparam int TIMEOUT      = (TOTAL_FRAMES * FRAME_CYCLES + MARGIN) * 2 * CLK_HALF;

	logic                bclk;
	logic                rst;
	logic                key_record;
	logic                key_play;
	logic                key_stop;
	logic [3:0]          speed;
	logic                interp;
	logic                adc_dat;
	logic                lrck;
	logic                dac_dat;
	logic [ADDR_W-1:0]   sram_addr;
	wire  [SAMPLE_W-1:0] sram_dq;
	logic                sram_we_n;
	logic                sram_oe_n;
	aud_state_e          state;

	logic [31:0]         lfsr;
	logic [SAMPLE_W-1:0] cur_left;
	logic [SAMPLE_W-1:0] dac_q [$];
	logic [SAMPLE_W-1:0] exp_q [$];
	logic [SAMPLE_W-1:0] stored [0:15];
	int                  stored_len;
	int                  errors;
	event                frame_ev;

	aud_top u_aud_top (
		.i_AUD_BCLK    (bclk),
		.i_rst_n       (rst),
		.i_key_record  (key_record),
		.i_key_play    (key_play),
		.i_key_stop    (key_stop),
		.i_speed       (speed),
		.i_interp      (interp),
		.i_AUD_ADCDAT  (adc_dat),
		.i_AUD_ADCLRCK (lrck),
		.i_AUD_DACLRCK (lrck),
		.o_AUD_DACDAT  (dac_dat),
		.o_SRAM_ADDR   (sram_addr),
		.io_SRAM_DQ    (sram_dq),
		.o_SRAM_WE_N   (sram_we_n),
		.o_SRAM_OE_N   (sram_oe_n),
		.o_state       (state)
	);

	sram_model u_sram (
		.i_addr (sram_addr),
		.io_dq  (sram_dq),
		.i_we_n (sram_we_n),
		.i_oe_n (sram_oe_n)
	);

	always #(CLK_HALF) bclk = ~bclk;

	// galois form with taps for a maximal 32-bit sequence
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// one lfsr step per bit
	task automatic draw_word(output logic [SAMPLE_W-1:0] w);
		for (int i = 0; i < SAMPLE_W; i++) begin
			w    = {w[SAMPLE_W-2:0], lfsr[0]};
			lfsr = lfsr_step(lfsr);
		end
	endtask

	task automatic check_equal(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, want);
			$display("Regression failed");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// single-cycle key pulse whose state change is seen on return
	task automatic press_key(input int which);
		@(negedge bclk);
		case (which)
			K_RECORD: key_record = 1'b1;
			K_PLAY:   key_play = 1'b1;
			default:  key_stop = 1'b1;
		endcase
		@(negedge bclk);
		key_record = 1'b0;
		key_play   = 1'b0;
		key_stop   = 1'b0;
	endtask

	// codec model with one lrck edge cycle and then 16 bits MSB first per slot
	initial begin : codec
		logic [SAMPLE_W-1:0] adc_word;
		logic [SAMPLE_W-1:0] dac_word;
		lfsr = 32'hef83;
		forever begin
			@(negedge bclk);
			lrck    = 1'b0;
			adc_dat = 1'b0;
			draw_word(adc_word);
			cur_left = adc_word;
			-> frame_ev;
			// dac bits are stable at the falling edge
			for (int i = SAMPLE_W - 1; i >= 0; i--) begin
				@(negedge bclk);
				adc_dat  = adc_word[i];
				dac_word = {dac_word[SAMPLE_W-2:0], dac_dat};
			end
			dac_q.push_back(dac_word);
			@(negedge bclk);
			lrck    = 1'b1;
			adc_dat = 1'b0;
			draw_word(adc_word);
			for (int i = SAMPLE_W - 1; i >= 0; i--) begin
				@(negedge bclk);
				adc_dat = adc_word[i];
			end
		end
	end

	// playback words from the stored recording
	task automatic build_expected(input logic slow, input logic lin, input int f);
		logic signed [SAMPLE_W-1:0] prev;
		logic signed [SAMPLE_W-1:0] cur;
		int                         d;
		exp_q = {};
		prev  = '0;
		if (!slow) begin
			for (int a = 0; a < stored_len; a += f)
				exp_q.push_back(stored[a]);
		end else begin
			for (int a = 0; a < stored_len; a++) begin
				cur = stored[a];
				for (int k = 0; k < f; k++) begin
					d = (int'(cur) - int'(prev)) * k;
					if (lin)
						exp_q.push_back(SAMPLE_W'(int'(prev) + (d >>> $clog2(f))));
					else
						exp_q.push_back(cur);
				end
				prev = cur;
			end
		end
	endtask

	task automatic check_reset_state();
		@(negedge bclk);
		check_equal("o_state", state, S_STOP);
		check_equal("o_SRAM_WE_N", sram_we_n, 1'b1);
		check_equal("o_AUD_DACDAT", dac_dat, 1'b0);
	endtask

	task automatic record_words();
		@(frame_ev);
		stored[0] = cur_left;
		press_key(K_RECORD);
		check_equal("o_state", state, S_RECD);
		check_equal("o_SRAM_OE_N", sram_oe_n, 1'b1);
		for (int i = 1; i < 12; i++) begin
			@(frame_ev);
			stored[i] = cur_left;
		end
		@(frame_ev);
		press_key(K_STOP);
		check_equal("o_state", state, S_STOP);
		check_equal("o_SRAM_OE_N", sram_oe_n, 1'b0);
		stored_len = 12;
		for (int i = 0; i < 12; i++)
			check_equal($sformatf("sram[%0d]", i), u_sram.peek(i), stored[i]);
		// nothing past the last left word
		check_equal("sram[12]", u_sram.peek(12), 16'hxxxx);
	endtask

	task automatic record_with_pause();
		@(frame_ev);
		stored[0] = cur_left;
		press_key(K_RECORD);
		check_equal("o_state", state, S_RECD);
		for (int i = 1; i < 4; i++) begin
			@(frame_ev);
			stored[i] = cur_left;
		end
		@(frame_ev);
		press_key(K_RECORD);
		check_equal("o_state", state, S_RECD_PAUSE);
		// three frames go by unrecorded
		repeat (3) @(frame_ev);
		stored[4] = cur_left;
		press_key(K_RECORD);
		check_equal("o_state", state, S_RECD);
		for (int i = 5; i < 8; i++) begin
			@(frame_ev);
			stored[i] = cur_left;
		end
		@(frame_ev);
		press_key(K_STOP);
		check_equal("o_state", state, S_STOP);
		stored_len = 8;
		// words 8 to 11 remain from the first recording
		for (int i = 0; i < 12; i++)
			check_equal($sformatf("sram[%0d]", i), u_sram.peek(i), stored[i]);
	endtask

	task automatic play_and_compare(input logic [3:0] spd, input logic lin);
		int f;
		int n;
		f = (spd[3] && lin) ? (1 << spd[1:0]) : (int'(spd[2:0]) + 1);
		build_expected(spd[3], spd[3] && lin, f);
		n = exp_q.size();
		@(frame_ev);
		dac_q  = {};
		speed  = spd;
		interp = lin;
		press_key(K_PLAY);
		check_equal("o_state", state, S_PLAY);
		do
			@(negedge bclk);
		while (state != S_STOP);
		while (dac_q.size() < n + 3)
			@(negedge bclk);
		// the first fetch reaches the DAC one frame after the start
		for (int i = 0; i < 2; i++)
			check_equal($sformatf("dac_word[%0d]", i), dac_q[i], '0);
		for (int i = 0; i < n; i++)
			check_equal($sformatf("dac_word[%0d]", i + 2), dac_q[i + 2], exp_q[i]);
		check_equal($sformatf("dac_word[%0d]", n + 2), dac_q[n + 2], '0);
	endtask

	task automatic pause_playback();
		build_expected(1'b0, 1'b0, 1);
		@(frame_ev);
		dac_q  = {};
		speed  = 4'd0;
		interp = 1'b0;
		press_key(K_PLAY);
		check_equal("o_state", state, S_PLAY);
		repeat (4) @(frame_ev);
		press_key(K_PLAY);
		check_equal("o_state", state, S_PLAY_PAUSE);
		repeat (4) @(frame_ev);
		press_key(K_STOP);
		check_equal("o_state", state, S_STOP);
		while (dac_q.size() < 9)
			@(negedge bclk);
		for (int i = 0; i < 3; i++)
			check_equal($sformatf("dac_word[%0d]", i + 2), dac_q[i + 2], exp_q[i]);
		for (int i = 5; i < 9; i++)
			check_equal($sformatf("dac_word[%0d]", i), dac_q[i], '0);
	endtask

	initial begin
		bclk       = 1'b0;
		rst        = 1'b1;
		key_record = 1'b0;
		key_play   = 1'b0;
		key_stop   = 1'b0;
		speed      = 4'd0;
		interp     = 1'b0;
		adc_dat    = 1'b0;
		lrck       = 1'b1;
		errors     = 0;
		stored_len = 0;
		repeat (4) @(negedge bclk);
		rst = 1'b0;
		check_reset_state();
		record_words();
		record_with_pause();
		// normal, fast x3, slow hold x2, slow linear x2
		play_and_compare(4'b0000, 1'b0);
		play_and_compare(4'b0010, 1'b0);
		play_and_compare(4'b1001, 1'b0);
		play_and_compare(4'b1001, 1'b1);
		pause_playback();
		if (errors == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			$display("Regression failed");
			$fatal(1, "%0d checks did not match", errors);
		end
	end

	initial begin
		#(TIMEOUT);
		$display("Regression failed");
		$fatal(1, "watchdog expired before the tests finished");
	end

endmodule
